/* verilog/keystream_macros.svh */
// Keystream generator widths and round count
// Shared by the package and the cipher core

`ifndef KEYSTREAM_MACROS_SVH
`define KEYSTREAM_MACROS_SVH

// Cipher block, one lane of keystream
`define KS_BLOCK_WIDTH 64

// Entropy part of the counter block
`define KS_NONCE_WIDTH 32

// Key as supplied by the caller
`define KS_KEY_WIDTH 64

// Rounds of the keyed permutation
// Core latency is one more than this for the final key XOR
`define KS_ROUNDS 8

`endif

/* verilog/keystreamPkg.sv */
// Keystream generator shared types
// Vector typedefs, slot work item and cipher FSM states

`include "keystream_macros.svh"

package keystreamPkg;

    //----------------------------------------------------------------------
    // Plain vectors
    //----------------------------------------------------------------------

    // One cipher block
    typedef logic [`KS_BLOCK_WIDTH-1:0] block_t;

    // Caller nonce, low part of the counter block
    typedef logic [`KS_NONCE_WIDTH-1:0] nonce_t;

    // Cipher key
    typedef logic [`KS_KEY_WIDTH-1:0] key_t;

    //----------------------------------------------------------------------
    // Work item and FSM
    //----------------------------------------------------------------------

    // Dispatcher to slot command, key in the upper bits
    typedef struct packed {
        key_t   key;
        nonce_t nonce;
    } loadCmd_t;

    // Round cipher control
    typedef enum logic [1:0] {
        Idle,
        Running,
        Done
    } cipherState_e;

endpackage

/* verilog/roundCipher.sv */
// Iterative keyed substitution-rotation cipher
// One round per cycle, result valid KS_ROUNDS+1 cycles after ld

`timescale 1ns/1ps
`include "keystream_macros.svh"

module roundCipher (
    input  logic                  Clock,
    input  logic                  rst,
    input  logic                  ld,
    input  keystreamPkg::key_t    key,
    input  keystreamPkg::block_t  textIn,
    output logic                  done,
    output keystreamPkg::block_t  textOut
);

    localparam int RoundWidth = $clog2(`KS_ROUNDS + 1);

    // 4-bit S-box, applied to every nibble
    localparam logic [3:0] Sbox [16] = '{
        4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
        4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
    };

    keystreamPkg::cipherState_e state;
    logic [RoundWidth-1:0]      roundCnt;
    keystreamPkg::block_t       blockReg;
    keystreamPkg::key_t         keyReg;
    keystreamPkg::key_t         roundKey;
    keystreamPkg::block_t       mixed;
    keystreamPkg::block_t       substituted;
    logic                       lastStep;

    // Key rotated left by 8 bits per round
    function automatic keystreamPkg::key_t rotKey(input keystreamPkg::key_t k,
                                                   input logic [RoundWidth-1:0] r);
        int unsigned amt;
        amt = (8 * r) % `KS_KEY_WIDTH;
        return (k << amt) | (k >> (`KS_KEY_WIDTH - amt));
    endfunction

    function automatic keystreamPkg::block_t subNibbles(input keystreamPkg::block_t b);
        keystreamPkg::block_t res;
        for (int i = 0; i < `KS_BLOCK_WIDTH / 4; i++) begin
            res[4*i +: 4] = Sbox[b[4*i +: 4]];
        end
        return res;
    endfunction

    //----------------------------------------------------------------------
    // Round datapath
    //----------------------------------------------------------------------

    assign roundKey    = rotKey(keyReg, roundCnt);
    assign mixed       = blockReg ^ keystreamPkg::block_t'(roundKey);
    assign substituted = subNibbles(mixed);
    // Counter sits at KS_ROUNDS for the closing key XOR
    assign lastStep    = (roundCnt == RoundWidth'(`KS_ROUNDS));

    // Payload registers, captured on ld so inputs may move afterwards
    always_ff @(posedge Clock) begin
        if (ld) begin
            blockReg <= textIn;
            keyReg   <= key;
        end else if (state == keystreamPkg::Running) begin
            if (lastStep)
                blockReg <= blockReg ^ keystreamPkg::block_t'(keyReg);
            else
                blockReg <= {substituted[`KS_BLOCK_WIDTH-14:0],
                             substituted[`KS_BLOCK_WIDTH-1:`KS_BLOCK_WIDTH-13]};
        end
    end

    // Control FSM, ld restarts from any state
    always_ff @(posedge Clock) begin
        if (rst) begin
            state    <= keystreamPkg::Idle;
            roundCnt <= '0;
        end else if (ld) begin
            state    <= keystreamPkg::Running;
            roundCnt <= '0;
        end else if (state == keystreamPkg::Running) begin
            if (lastStep)
                state <= keystreamPkg::Done;
            else
                roundCnt <= roundCnt + 1'b1;
        end
    end

    // Held until the next ld
    assign done    = (state == keystreamPkg::Done);
    assign textOut = blockReg;

endmodule

/* verilog/cipherSlot.sv */
// One keystream slot, Lanes cipher cores on consecutive counters
// Busy from load until release, done once every lane has finished

`timescale 1ns/1ps

module cipherSlot #(
    parameter int Lanes = 4
) (
    input  logic                               Clock,
    input  logic                               rst,
    input  logic                               load,
    input  keystreamPkg::loadCmd_t             cmd,
    input  logic                               releaseSlot,
    output logic                               busy,
    output logic                               done,
    output keystreamPkg::block_t [Lanes-1:0]   result
);

    logic [Lanes-1:0] laneDone;

    //----------------------------------------------------------------------
    // Lane cores
    //----------------------------------------------------------------------

    for (genvar j = 0; j < Lanes; j++) begin : g_lane
        keystreamPkg::nonce_t laneNonce;
        keystreamPkg::block_t laneBlock;

        // Counter wraps modulo 2^32 within the nonce field
        assign laneNonce = cmd.nonce + keystreamPkg::nonce_t'(j);
        // Zero-extended into the block
        assign laneBlock = keystreamPkg::block_t'(laneNonce);

        roundCipher i_core (
            .Clock   (Clock),
            .rst     (rst),
            .ld      (load),
            .key     (cmd.key),
            .textIn  (laneBlock),
            .done    (laneDone[j]),
            .textOut (result[j])
        );
    end

    // Slot ownership
    // Load and release never hit the same slot together
    always_ff @(posedge Clock) begin
        if (rst)
            busy <= 1'b0;
        else if (load)
            busy <= 1'b1;
        else if (releaseSlot)
            busy <= 1'b0;
    end

    // Stale done from an old run is masked by busy
    assign done = busy & (&laneDone);

endmodule

/* verilog/slotDispatcher.sv */
// Input side of the keystream generator
// Accepts nonce and key, loads the slot under the turn pointer

`timescale 1ns/1ps

module slotDispatcher #(
    parameter int Slots = 4
) (
    input  logic                    Clock,
    input  logic                    rst,

    // Nonce channel
    input  keystreamPkg::nonce_t    DataIn,
    input  logic                    DataInValid,
    output logic                    DataInReady,

    // Key channel, ready mirrors the nonce channel
    input  keystreamPkg::key_t      Key,
    input  logic                    KeyValid,
    output logic                    KeyReady,

    // Slot side
    input  logic [Slots-1:0]        slotBusy,
    output logic [Slots-1:0]        load,
    output keystreamPkg::loadCmd_t  loadCmd
);

    localparam int SlotIdxWidth = $clog2(Slots);

    logic [SlotIdxWidth-1:0] inTurn;
    logic                    accept;

    //----------------------------------------------------------------------
    // Handshake
    //----------------------------------------------------------------------

    // Only the slot whose turn it is may take work
    // Keeps slot order equal to acceptance order
    assign DataInReady = ~slotBusy[inTurn];
    assign KeyReady    = DataInReady;

    // Both channels must present together
    assign accept = DataInValid & KeyValid & DataInReady;

    // One-hot load in the accepting cycle
    assign load = accept ? (Slots'(1) << inTurn) : '0;

    // Command shared by every slot, qualified by load
    assign loadCmd.key   = Key;
    assign loadCmd.nonce = DataIn;

    //----------------------------------------------------------------------
    // Turn pointer
    //----------------------------------------------------------------------

    // Round-robin over slots, wraps at Slots-1
    always_ff @(posedge Clock) begin
        if (rst) begin
            inTurn <= '0;
        end else if (accept) begin
            if (inTurn == SlotIdxWidth'(Slots - 1))
                inTurn <= '0;
            else
                inTurn <= inTurn + 1'b1;
        end
    end

endmodule

/* verilog/resultCollector.sv */
// Output side of the keystream generator
// Presents the oldest slot's result, releases it after transfer

`timescale 1ns/1ps

module resultCollector #(
    parameter int Lanes = 4,
    parameter int Slots = 4
) (
    input  logic                                         Clock,
    input  logic                                         rst,

    // Slot side
    input  logic [Slots-1:0]                             slotDone,
    input  keystreamPkg::block_t [Slots-1:0][Lanes-1:0]  slotResult,
    output logic [Slots-1:0]                             slotRelease,

    // Keystream channel, lane 0 in the low bits
    output keystreamPkg::block_t [Lanes-1:0]             DataOut,
    output logic                                         DataOutValid,
    input  logic                                         DataOutReady
);

    localparam int SlotIdxWidth = $clog2(Slots);

    logic [SlotIdxWidth-1:0] outTurn;
    logic                    transfer;

    //----------------------------------------------------------------------
    // Output select
    //----------------------------------------------------------------------

    // Oldest outstanding slot only
    // Slot holds its result until released, so a stall is stable
    assign DataOutValid = slotDone[outTurn];
    assign DataOut      = slotResult[outTurn];

    assign transfer = DataOutValid & DataOutReady;

    // Single-cycle release back to the drained slot
    assign slotRelease = transfer ? (Slots'(1) << outTurn) : '0;

    //----------------------------------------------------------------------
    // Turn pointer
    //----------------------------------------------------------------------

    // Follows the dispatcher's order, one step per transfer
    always_ff @(posedge Clock) begin
        if (rst) begin
            outTurn <= '0;
        end else if (transfer) begin
            if (outTurn == SlotIdxWidth'(Slots - 1))
                outTurn <= '0;
            else
                outTurn <= outTurn + 1'b1;
        end
    end

endmodule

/* verilog/keystreamTop.sv */
// Counter-mode keystream generator top level
// Dispatcher, round-robin cipher slots and in-order collector

`timescale 1ns/1ps

module keystreamTop #(
    parameter int Lanes = 4,
    parameter int Slots = 4
) (
    input  logic                              Clock,
    input  logic                              rst,

    input  keystreamPkg::nonce_t              DataIn,
    input  logic                              DataInValid,
    output logic                              DataInReady,

    input  keystreamPkg::key_t                Key,
    input  logic                              KeyValid,
    output logic                              KeyReady,

    output keystreamPkg::block_t [Lanes-1:0]  DataOut,
    output logic                              DataOutValid,
    input  logic                              DataOutReady
);

    //----------------------------------------------------------------------
    // Internal wiring
    //----------------------------------------------------------------------

    logic [Slots-1:0]                             slotLoad;
    keystreamPkg::loadCmd_t                       loadCmd;
    logic [Slots-1:0]                             slotBusy;
    logic [Slots-1:0]                             slotDone;
    logic [Slots-1:0]                             slotRelease;
    keystreamPkg::block_t [Slots-1:0][Lanes-1:0]  slotResult;

    slotDispatcher #(
        .Slots (Slots)
    ) i_dispatcher (
        .Clock       (Clock),
        .rst         (rst),
        .DataIn      (DataIn),
        .DataInValid (DataInValid),
        .DataInReady (DataInReady),
        .Key         (Key),
        .KeyValid    (KeyValid),
        .KeyReady    (KeyReady),
        .slotBusy    (slotBusy),
        .load        (slotLoad),
        .loadCmd     (loadCmd)
    );

    // Slots, each with Lanes cores
    for (genvar s = 0; s < Slots; s++) begin : g_slot
        cipherSlot #(
            .Lanes (Lanes)
        ) i_slot (
            .Clock       (Clock),
            .rst         (rst),
            .load        (slotLoad[s]),
            .cmd         (loadCmd),
            .releaseSlot (slotRelease[s]),
            .busy        (slotBusy[s]),
            .done        (slotDone[s]),
            .result      (slotResult[s])
        );
    end

    resultCollector #(
        .Lanes (Lanes),
        .Slots (Slots)
    ) i_collector (
        .Clock        (Clock),
        .rst          (rst),
        .slotDone     (slotDone),
        .slotResult   (slotResult),
        .slotRelease  (slotRelease),
        .DataOut      (DataOut),
        .DataOutValid (DataOutValid),
        .DataOutReady (DataOutReady)
    );

endmodule

/* dv/clockGen.sv */
// Testbench clock and reset source
// 100 ns period with reset held over the first two rising edges

`timescale 1ns/1ps

module clockGen (
    output logic Clock,
    output logic rst
);

    localparam int HalfPeriod = 50;

    initial begin
        Clock = 1'b0;
        forever #HalfPeriod Clock = ~Clock;
    end

    // Released 1 ns after the second edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge Clock);
        #1;
        rst = 1'b0;
    end

endmodule

/* dv/keystreamTb.sv */
// Keystream generator testbench
// Vectors from the data file checked against a reference model of the cipher

`timescale 1ns/1ps
`include "keystream_macros.svh"

module keystreamTb;

    localparam int Lanes   = 4;
    localparam int Slots   = 4;
    localparam int Timeout = 200;
    localparam int MaxVec  = 64;
    // Nibble n of the S-box at bits 4n
    localparam logic [63:0] SboxTable = 64'h2174_8FE3_DA09_B65C;

    logic                              Clock;
    logic                              rst;
    keystreamPkg::nonce_t              DataIn;
    logic                              DataInValid;
    logic                              DataInReady;
    keystreamPkg::key_t                Key;
    logic                              KeyValid;
    logic                              KeyReady;
    keystreamPkg::block_t [Lanes-1:0]  DataOut;
    logic                              DataOutValid;
    logic                              DataOutReady;

    int mismatches = 0;
    int failures   = 0;
    int cycleCount = 0;
    int numVec     = 0;

    // Vector table
    int                   vecCode  [MaxVec];
    keystreamPkg::key_t   vecKey   [MaxVec];
    keystreamPkg::nonce_t vecNonce [MaxVec];
    int                   vecStall [MaxVec];

    // Accepted requests with the oldest first
    keystreamPkg::loadCmd_t expectQ [$];
    int                     acceptQ [$];

    clockGen i_clk (
        .Clock (Clock),
        .rst   (rst)
    );

    keystreamTop #(
        .Lanes (Lanes),
        .Slots (Slots)
    ) i_dut (
        .Clock        (Clock),
        .rst          (rst),
        .DataIn       (DataIn),
        .DataInValid  (DataInValid),
        .DataInReady  (DataInReady),
        .Key          (Key),
        .KeyValid     (KeyValid),
        .KeyReady     (KeyReady),
        .DataOut      (DataOut),
        .DataOutValid (DataOutValid),
        .DataOutReady (DataOutReady)
    );

    always @(posedge Clock) cycleCount++;

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------

    function automatic keystreamPkg::block_t refLane(input keystreamPkg::key_t key,
                                                     input keystreamPkg::nonce_t nonce,
                                                     input int lane);
        keystreamPkg::block_t state;
        keystreamPkg::key_t   roundKey;
        state        = '0;
        state[31:0]  = nonce + keystreamPkg::nonce_t'(lane);
        roundKey     = key;
        for (int r = 0; r < `KS_ROUNDS; r++) begin
            state = state ^ roundKey;
            for (int i = 0; i < 16; i++)
                state[4*i +: 4] = SboxTable[4*state[4*i +: 4] +: 4];
            // Rotate left by 13
            state    = {state[50:0], state[63:51]};
            // Next round key is one byte further round
            roundKey = {roundKey[55:0], roundKey[63:56]};
        end
        return state ^ key;
    endfunction

    function automatic string testName(input int code);
        case (code)
            1:       return "single";
            2:       return "burst";
            3:       return "backpressure";
            4:       return "fullslots";
            5:       return "keychange";
            default: return "unknown";
        endcase
    endfunction

    //----------------------------------------------------------------------
    // Checking and run control
    //----------------------------------------------------------------------

    task automatic checkValue(input string name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic finishRun();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    endtask

    task automatic abortRun(input string reason);
        failures++;
        $display("%s", reason);
        finishRun();
    endtask

    task automatic readVectors();
        int    fd;
        int    count;
        string line;
        fd = $fopen("dv/keystream_input.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the vector file dv/keystream_input.txt");
        end else begin
            while (!$feof(fd) && numVec < MaxVec && failures == 0) begin
                line = "";
                void'($fgets(line, fd));
                // Skip column notes and blank lines
                if (line.len() > 4 && line.getc(0) != "#") begin
                    count = $sscanf(line, "%d %h %h %d", vecCode[numVec], vecKey[numVec],
                                    vecNonce[numVec], vecStall[numVec]);
                    if (count == 4)
                        numVec++;
                    else
                        abortRun("A line of the vector file could not be parsed");
                end
            end
            $fclose(fd);
        end
    endtask

    //----------------------------------------------------------------------
    // Drivers enter and leave 1 ns after a rising edge
    //----------------------------------------------------------------------

    task automatic sendVector(input int idx);
        keystreamPkg::loadCmd_t cmd;
        int                     waited;
        bit                     accepted;
        waited        = 0;
        accepted      = 1'b0;
        DataIn        = vecNonce[idx];
        Key           = vecKey[idx];
        DataInValid   = 1'b1;
        KeyValid      = 1'b1;
        while (!accepted) begin
            @(negedge Clock);
            accepted = DataInReady;
            checkValue(testName(vecCode[idx]), "KeyReady", DataInReady, KeyReady);
            @(posedge Clock);
            #1;
            waited++;
            if (!accepted && waited > Timeout)
                abortRun("Timeout waiting for DataInReady");
        end
        DataInValid = 1'b0;
        KeyValid    = 1'b0;
        cmd.key     = vecKey[idx];
        cmd.nonce   = vecNonce[idx];
        expectQ.push_back(cmd);
        acceptQ.push_back(cycleCount);
    endtask

    task automatic checkOutput(input string name, input keystreamPkg::loadCmd_t cmd);
        checkValue(name, "DataOutValid", 1, DataOutValid);
        for (int j = 0; j < Lanes; j++)
            checkValue(name, $sformatf("lane %0d", j), refLane(cmd.key, cmd.nonce, j),
                       DataOut[j]);
    endtask

    // One transfer with ready held low for stall cycles once valid is up
    task automatic receiveBlock(input int stall, input bit checkLatency, input string name);
        keystreamPkg::loadCmd_t cmd;
        int                     waited;
        waited       = 0;
        DataOutReady = (stall == 0);
        @(negedge Clock);
        while (!DataOutValid) begin
            waited++;
            if (waited > Timeout)
                abortRun("Timeout waiting for DataOutValid");
            @(negedge Clock);
        end
        if (expectQ.size() == 0) begin
            abortRun("DataOutValid rose with no request outstanding");
        end else begin
            cmd = expectQ[0];
            if (checkLatency)
                checkValue(name, "latency", `KS_ROUNDS + 1, cycleCount - acceptQ[0]);
            for (int s = 0; s <= stall; s++) begin
                if (s > 0)
                    @(negedge Clock);
                checkOutput(name, cmd);
                @(posedge Clock);
                #1;
                DataOutReady = (s == stall - 1);
            end
            void'(expectQ.pop_front());
            void'(acceptQ.pop_front());
        end
    endtask

    //----------------------------------------------------------------------
    // Tests
    //----------------------------------------------------------------------

    // Random input gaps and output stalls with outputs in order
    task automatic runStream(input int code, input int maxGap, input int maxStall);
        int idx [$];
        for (int i = 0; i < numVec; i++)
            if (vecCode[i] == code)
                idx.push_back(i);
        fork
            foreach (idx[k]) begin
                repeat ($urandom % (maxGap + 1)) begin
                    @(posedge Clock);
                    #1;
                end
                sendVector(idx[k]);
            end
            repeat (idx.size())
                receiveBlock($urandom % (maxStall + 1), 1'b0, testName(code));
        join
    endtask

    task automatic runBackPressure();
        int stall;
        for (int i = 0; i < numVec; i++) begin
            if (vecCode[i] == 3) begin
                stall = (vecStall[i] > 0) ? vecStall[i] : 1 + $urandom % 12;
                sendVector(i);
                receiveBlock(stall, 1'b0, "backpressure");
            end
        end
    endtask

    task automatic runFullSlots();
        int idx [$];
        int start;
        for (int i = 0; i < numVec; i++)
            if (vecCode[i] == 4)
                idx.push_back(i);
        if (idx.size() <= Slots)
            abortRun("The vector file holds too few full-slot vectors");
        DataOutReady = 1'b0;
        for (int k = 0; k < Slots; k++)
            sendVector(idx[k]);
        // Every slot now holds a result so the next request has to wait
        DataIn      = vecNonce[idx[Slots]];
        Key         = vecKey[idx[Slots]];
        DataInValid = 1'b1;
        KeyValid    = 1'b1;
        repeat (2 * (`KS_ROUNDS + 1)) begin
            @(negedge Clock);
            checkValue("fullslots", "DataInReady", 0, DataInReady);
            checkValue("fullslots", "KeyReady", 0, KeyReady);
            @(posedge Clock);
            #1;
        end
        receiveBlock(0, 1'b0, "fullslots");
        // Freed slot takes the waiting request on the next edge
        start = cycleCount;
        sendVector(idx[Slots]);
        checkValue("fullslots", "cycles to accept", 1, acceptQ[acceptQ.size() - 1] - start);
        fork
            for (int k = Slots + 1; k < idx.size(); k++)
                sendVector(idx[k]);
            repeat (idx.size() - 1)
                receiveBlock(0, 1'b0, "fullslots");
        join
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------

    initial begin
        int unsigned seed;
        int          waited;
        DataIn       = '0;
        DataInValid  = 1'b0;
        Key          = '0;
        KeyValid     = 1'b0;
        DataOutReady = 1'b0;
        seed         = 32'hecd9_89f9;
        void'($urandom(seed));
        readVectors();

        // Reset is sampled away from the edges
        waited = 0;
        @(negedge Clock);
        while (rst !== 1'b0) begin
            waited++;
            if (waited > Timeout)
                abortRun("Timeout waiting for reset to be released");
            @(negedge Clock);
        end
        checkValue("reset", "DataInReady", 1, DataInReady);
        checkValue("reset", "KeyReady", 1, KeyReady);
        checkValue("reset", "DataOutValid", 0, DataOutValid);
        @(posedge Clock);
        #1;

        // Single block with exact latency
        DataOutReady = 1'b1;
        for (int i = 0; i < numVec; i++) begin
            if (vecCode[i] == 1) begin
                sendVector(i);
                receiveBlock(0, 1'b1, "single");
            end
        end

        runStream(2, 3, 2);
        runBackPressure();
        runFullSlots();
        runStream(5, 0, 0);

        repeat (4) @(posedge Clock);
        finishRun();
    end

endmodule

/* keystreamGen.f */
+incdir+verilog
verilog/keystreamPkg.sv
verilog/roundCipher.sv
verilog/cipherSlot.sv
verilog/slotDispatcher.sv
verilog/resultCollector.sv
verilog/keystreamTop.sv
dv/clockGen.sv
dv/keystreamTb.sv

/* dv/keystream_input.txt */
# columns: test code, key (hex), nonce (hex), stall cycles (decimal)
# codes 1 single 2 burst 3 back-pressure 4 full slots 5 key change, stall 0 means random
1 0123456789abcdef 00000000 0
2 0f1e2d3c4b5a6978 00000010 0
2 0f1e2d3c4b5a6978 fffffffe 0
2 a5a5a5a55a5a5a5a 7fffffff 0
2 a5a5a5a55a5a5a5a fffffffd 0
2 0000000000000000 12345678 0
2 ffffffffffffffff ffffffff 0
3 1122334455667788 0badf00d 5
3 1122334455667788 deadbeef 0
3 8877665544332211 00000003 12
4 13579bdf2468ace0 00001000 0
4 13579bdf2468ace0 00002000 0
4 2468ace013579bdf 00003000 0
4 2468ace013579bdf 00004000 0
4 fedcba9876543210 00005000 0
4 fedcba9876543210 fffffffc 0
5 0000000000000001 00000100 0
5 8000000000000000 00000100 0
5 c3c3c3c33c3c3c3c 00000100 0
5 0102040810204080 00000100 0
